// File: logic/sd_resp_pkg.sv
/* SD SPI response checker package
   Widths, command offsets, step counts and compare constants */

`default_nettype none

package sd_resp_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and vector types
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned DataWidth = 32;
    localparam int unsigned AddrBits  = 8;
    localparam int unsigned IdWidth   = 5;

    typedef logic [DataWidth-1:0] data_t;
    typedef logic [AddrBits-1:0]  offset_t;
    typedef logic [7:0]           cnt_t;
    // Response bit length minus one
    typedef logic [5:0]           len_t;
    typedef logic [IdWidth-1:0]   id_t;

    ////////////////////////////////////////////////////////////////////////////
    // Register offsets, one per card command
    ////////////////////////////////////////////////////////////////////////////

    localparam offset_t IdleOffset   = 8'h00;
    localparam offset_t BufferOffset = 8'h04;
    localparam offset_t BaudOffset   = 8'h08;
    localparam offset_t Cmd0Offset   = 8'h0C;
    localparam offset_t Cmd8Offset   = 8'h10;
    localparam offset_t Cmd59Offset  = 8'h14;
    localparam offset_t Cmd58Offset  = 8'h18;
    localparam offset_t Acmd41Offset = 8'h1C;
    // Plain single-block read/write range
    localparam offset_t RwMinOffset  = 8'h20;
    localparam offset_t RwMaxOffset  = 8'h7F;

    // Step counts of the data-block responses
    localparam cnt_t WrTokenCnt = 8'd68;
    localparam cnt_t RdTokenCnt = 8'd130;
    localparam cnt_t RdDataCnt  = 8'd128;
    localparam cnt_t BusyCnt    = 8'd198;

    ////////////////////////////////////////////////////////////////////////////
    // Compare words and masks
    ////////////////////////////////////////////////////////////////////////////

    // R1 with only the idle bit set
    localparam data_t R1IdleResp   = 32'h0000_0001;
    localparam data_t ReadyResp    = 32'h0000_0000;
    localparam data_t Cmd8R7Resp   = 32'h0100_0001;
    // Check pattern echoed back by CMD8
    localparam data_t Cmd8EchoResp = 32'h0000_00AA;
    localparam data_t EchoMask     = 32'h0000_00FF;
    localparam data_t Cmd58OcrResp = 32'h0100_FF80;
    localparam data_t Cmd58OcrMask = 32'hFF00_0000;
    localparam data_t WrTokenResp  = 32'h0000_0005;
    localparam data_t WrTokenMask  = 32'h0000_001F;
    // Idle line while the card is busy
    localparam data_t FillResp     = 32'hFFFF_FFFF;
    localparam data_t FillMask     = 32'h0000_0001;

    // How the response of the current step is judged
    typedef enum logic [2:0] {
        PASSTHROUGH,
        VALIDATE,
        ERROR,
        FINAL,
        CAUSE_ERROR,
        CAUSE_VALIDATION,
        CHECK_IF_DATA
    } resp_type_e;

endpackage

`default_nettype wire

// File: logic/sd_cmd_expect.sv
/* Expected response decoder
   Registers type, compare word and mask on each SPI clock rising edge */

`timescale 1ns/10ps
`default_nettype none

module sd_cmd_expect (
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,
    input  wire logic                   spi_clk_i,
    input  wire logic                   req_i,
    input  wire logic                   we_i,
    input  wire sd_resp_pkg::offset_t   addr_i,
    input  wire sd_resp_pkg::cnt_t      cnt_cmd_i,
    input  wire sd_resp_pkg::len_t      len_cmd_i,
    input  wire logic                   en_write_i,
    output sd_resp_pkg::resp_type_e     resp_type_o,
    output sd_resp_pkg::data_t          cmp_data_o,
    output sd_resp_pkg::data_t          cmp_mask_o
);

    import sd_resp_pkg::*;

    logic       spi_clk_q;
    logic       spi_rise;
    logic       in_rw_range;
    data_t      mask_dflt;
    resp_type_e type_d;
    data_t      cmp_d;
    data_t      mask_d;

    ////////////////////////////////////////////////////////////////////////////
    // SPI clock edge detection
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            spi_clk_q <= 1'b0;
        end else begin
            spi_clk_q <= spi_clk_i;
        end
    end

    assign spi_rise = spi_clk_i && !spi_clk_q;

    // Keep the low len+1 bits of the response
    always_comb begin
        if (len_cmd_i >= len_t'(DataWidth - 1)) begin
            mask_dflt = '1;
        end else begin
            mask_dflt = ~(data_t'('1) << (len_cmd_i + 6'd1));
        end
    end

    assign in_rw_range = req_i && (addr_i >= RwMinOffset) && (addr_i <= RwMaxOffset);

    ////////////////////////////////////////////////////////////////////////////
    // Command sequence table
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        type_d = PASSTHROUGH;
        cmp_d  = ReadyResp;
        mask_d = mask_dflt;

        case (addr_i)
            IdleOffset, BufferOffset: begin
                if (cnt_cmd_i == 8'd1) begin
                    type_d = VALIDATE;
                end
            end
            BaudOffset: begin
                type_d = we_i ? VALIDATE : ERROR;
            end
            Cmd0Offset, Cmd59Offset: begin
                if (!en_write_i) begin
                    type_d = FINAL;
                    cmp_d  = R1IdleResp;
                end
            end
            Cmd8Offset: begin
                if (cnt_cmd_i == 8'd2) begin
                    type_d = CAUSE_ERROR;
                    cmp_d  = Cmd8R7Resp;
                end else begin
                    type_d = FINAL;
                    cmp_d  = Cmd8EchoResp;
                    mask_d = EchoMask;
                end
            end
            Cmd58Offset: begin
                if (cnt_cmd_i == 8'd2) begin
                    type_d = CAUSE_ERROR;
                    cmp_d  = Cmd58OcrResp;
                    mask_d = Cmd58OcrMask;
                end else begin
                    type_d = VALIDATE;
                end
            end
            Acmd41Offset: begin
                // Init loop repeats every 8 steps until the card leaves idle
                if (cnt_cmd_i[2:0] == 3'd2) begin
                    type_d = CAUSE_VALIDATION;
                end else if (cnt_cmd_i == 8'd1) begin
                    type_d = CAUSE_ERROR;
                end
            end
            default: begin
                if (in_rw_range && we_i) begin
                    if (cnt_cmd_i == BusyCnt) begin
                        type_d = CAUSE_ERROR;
                    end else if (cnt_cmd_i == WrTokenCnt) begin
                        type_d = CAUSE_ERROR;
                        cmp_d  = WrTokenResp;
                        mask_d = WrTokenMask;
                    end else if (cnt_cmd_i == 8'd1) begin
                        type_d = ERROR;
                    end else if (cnt_cmd_i > 8'd1 && cnt_cmd_i < WrTokenCnt) begin
                        // Card still busy, line high until the end
                        type_d = CAUSE_VALIDATION;
                        cmp_d  = FillResp;
                        mask_d = FillMask;
                    end
                end else if (in_rw_range) begin
                    if (cnt_cmd_i == RdTokenCnt) begin
                        type_d = CAUSE_ERROR;
                    end else if (cnt_cmd_i == 8'd1) begin
                        type_d = ERROR;
                    end else if (cnt_cmd_i > 8'd1 && cnt_cmd_i < RdDataCnt) begin
                        type_d = CHECK_IF_DATA;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resp_type_o <= PASSTHROUGH;
        end else if (spi_rise) begin
            resp_type_o <= type_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (spi_rise) begin
            cmp_data_o <= cmp_d;
            cmp_mask_o <= mask_d;
        end
    end

endmodule

`default_nettype wire

// File: logic/sd_resp_judge.sv
/* Response judge
   Compares the finished response and issues correct or error pulses */

`timescale 1ns/10ps
`default_nettype none

module sd_resp_judge (
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,
    input  wire sd_resp_pkg::resp_type_e resp_type_i,
    input  wire sd_resp_pkg::data_t     cmp_data_i,
    input  wire sd_resp_pkg::data_t     cmp_mask_i,
    input  wire sd_resp_pkg::data_t     data_i,
    input  wire logic                   start_bit_i,
    input  wire logic                   last_bit_i,
    input  wire logic                   en_write_i,
    output logic                        correct_o,
    output logic                        error_o
);

    import sd_resp_pkg::*;

    logic read_phase_q;
    logic last_bit_q;
    logic verdict;
    logic match;

    // Start bit opens a read phase, the last bit closes it
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            read_phase_q <= 1'b0;
            last_bit_q   <= 1'b0;
        end else begin
            last_bit_q <= last_bit_i;
            if (start_bit_i) begin
                read_phase_q <= 1'b1;
            end else if (last_bit_i) begin
                read_phase_q <= 1'b0;
            end
        end
    end

    // Only on the first cycle of the last bit, and never while writing
    assign verdict = last_bit_i && !last_bit_q && !en_write_i;
    assign match   = ((data_i ^ cmp_data_i) & cmp_mask_i) == '0;

    always_comb begin
        correct_o = 1'b0;
        error_o   = 1'b0;
        if (verdict) begin
            case (resp_type_i)
                FINAL: begin
                    correct_o = match;
                    error_o   = !match;
                end
                CAUSE_ERROR: begin
                    error_o = !match;
                end
                CAUSE_VALIDATION: begin
                    correct_o = match;
                end
                VALIDATE: begin
                    correct_o = 1'b1;
                end
                ERROR: begin
                    error_o = 1'b1;
                end
                CHECK_IF_DATA: begin
                    correct_o = read_phase_q;
                end
                default: begin
                    correct_o = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/sd_obi_resp.sv
/* Bus response stage
   Drives grant and the one-cycle response phase from the verdict */

`timescale 1ns/10ps
`default_nettype none

module sd_obi_resp #(
    parameter int unsigned IdWidth = 5
) (
    input  wire logic               clk_i,
    input  wire logic               arst_n_i,
    input  wire logic               correct_i,
    input  wire logic               error_i,
    input  wire logic               req_i,
    input  wire logic [IdWidth-1:0] aid_i,
    input  wire sd_resp_pkg::data_t data_i,
    output logic                    gnt_o,
    output logic                    rvalid_o,
    output logic                    err_o,
    output logic [IdWidth-1:0]      rid_o,
    output sd_resp_pkg::data_t      rdata_o
);

    logic correct_q;
    logic error_q;

    // Verdict moves into the response phase
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            correct_q <= 1'b0;
            error_q   <= 1'b0;
        end else begin
            correct_q <= correct_i;
            error_q   <= error_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rid_o <= aid_i;
    end

    // Grant on the verdict, idle bus is always granted
    assign gnt_o    = correct_i || error_i || !req_i;
    assign rvalid_o = correct_q || error_q;
    assign err_o    = error_q;
    assign rdata_o  = data_i;

endmodule

`default_nettype wire

// File: logic/sd_resp_checker.sv
/* SD SPI-mode response checker
   Decodes the expected response, judges it and answers the bus */

`timescale 1ns/10ps
`default_nettype none

module sd_resp_checker #(
    parameter int unsigned IdWidth = $bits(sd_resp_pkg::id_t)
) (
    input  wire logic                 clk_i,
    input  wire logic                 arst_n_i,
    input  wire logic                 spi_clk_i,
    // Bus request
    input  wire logic                 req_i,
    input  wire logic                 we_i,
    input  wire sd_resp_pkg::offset_t addr_i,
    input  wire logic [IdWidth-1:0]   aid_i,
    // Shifter and counter
    input  wire sd_resp_pkg::data_t   data_i,
    input  wire sd_resp_pkg::cnt_t    cnt_cmd_i,
    input  wire sd_resp_pkg::len_t    len_cmd_i,
    input  wire logic                 en_write_i,
    input  wire logic                 start_bit_i,
    input  wire logic                 last_bit_i,
    output logic                      done_o,
    // Bus response
    output logic                      gnt_o,
    output logic                      rvalid_o,
    output sd_resp_pkg::data_t        rdata_o,
    output logic [IdWidth-1:0]        rid_o,
    output logic                      err_o
);

    import sd_resp_pkg::*;

    resp_type_e resp_type;
    data_t      cmp_data;
    data_t      cmp_mask;
    logic       correct;
    logic       error;

    sd_cmd_expect u_expect (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .spi_clk_i  (spi_clk_i),
        .req_i      (req_i),
        .we_i       (we_i),
        .addr_i     (addr_i),
        .cnt_cmd_i  (cnt_cmd_i),
        .len_cmd_i  (len_cmd_i),
        .en_write_i (en_write_i),
        .resp_type_o(resp_type),
        .cmp_data_o (cmp_data),
        .cmp_mask_o (cmp_mask)
    );

    sd_resp_judge u_judge (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .resp_type_i(resp_type),
        .cmp_data_i (cmp_data),
        .cmp_mask_i (cmp_mask),
        .data_i     (data_i),
        .start_bit_i(start_bit_i),
        .last_bit_i (last_bit_i),
        .en_write_i (en_write_i),
        .correct_o  (correct),
        .error_o    (error)
    );

    sd_obi_resp #(
        .IdWidth(IdWidth)
    ) u_resp (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .correct_i(correct),
        .error_i  (error),
        .req_i    (req_i),
        .aid_i    (aid_i),
        .data_i   (data_i),
        .gnt_o    (gnt_o),
        .rvalid_o (rvalid_o),
        .err_o    (err_o),
        .rid_o    (rid_o),
        .rdata_o  (rdata_o)
    );

    // Command step finished, either way
    assign done_o = correct || error;

endmodule

`default_nettype wire

// File: tb/sd_resp_checker_properties.sv
/* Bus response assertions, bound into the response checker */

`timescale 1ns/10ps
`default_nettype none

module sd_resp_checker_properties (
    input wire logic clk_i,
    input wire logic arst_n_i,
    input wire logic req_i,
    input wire logic done_i,
    input wire logic gnt_i,
    input wire logic rvalid_i,
    input wire logic err_i
);

    // An error response is still a response
    err_with_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        err_i |-> rvalid_i)
        else $error("err_o high without rvalid_o");

    // Response phase one cycle after the verdict
    valid_after_done: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rvalid_i == $past(done_i))
        else $error("rvalid_o does not follow done_o by one cycle");

    idle_granted: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !req_i |-> gnt_i)
        else $error("gnt_o low while no request is pending");

endmodule

bind sd_resp_checker sd_resp_checker_properties u_properties (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .req_i   (req_i),
    .done_i  (done_o),
    .gnt_i   (gnt_o),
    .rvalid_i(rvalid_o),
    .err_i   (err_o)
);

`default_nettype wire

// File: tb/tb_sd_resp_checker.sv
/* Testbench for the SD SPI response checker
   Runs a table of command steps and checks verdict, grant and response */

`timescale 1ns/10ps
`default_nettype none

module tb_sd_resp_checker;

    import sd_resp_pkg::*;

    localparam int NumRows       = 20;
    localparam int TimeoutCycles = NumRows * 20;

    logic    clk;
    logic    arst_n;
    logic    spi_clk;
    logic    req;
    logic    we;
    offset_t addr;
    id_t     aid;
    data_t   data;
    cnt_t    cnt_cmd;
    len_t    len_cmd;
    logic    en_write;
    logic    start_bit;
    logic    last_bit;
    logic    done;
    logic    gnt;
    logic    rvalid;
    data_t   rdata;
    id_t     rid;
    logic    err;

    integer      seed = 36160;
    int          checks = 0;
    int          errors = 0;
    int unsigned cycle_cnt = 0;

    // Stimulus and expected response, one row per command step
    int      n_rows = 0;
    offset_t row_addr      [NumRows];
    logic    row_we        [NumRows];
    cnt_t    row_cnt       [NumRows];
    len_t    row_len       [NumRows];
    logic    row_en_write  [NumRows];
    data_t   row_data      [NumRows];
    logic    row_start     [NumRows];
    logic    row_exp_valid [NumRows];
    logic    row_exp_err   [NumRows];

    sd_resp_checker #(
        .IdWidth($bits(id_t))
    ) dut (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .spi_clk_i  (spi_clk),
        .req_i      (req),
        .we_i       (we),
        .addr_i     (addr),
        .aid_i      (aid),
        .data_i     (data),
        .cnt_cmd_i  (cnt_cmd),
        .len_cmd_i  (len_cmd),
        .en_write_i (en_write),
        .start_bit_i(start_bit),
        .last_bit_i (last_bit),
        .done_o     (done),
        .gnt_o      (gnt),
        .rvalid_o   (rvalid),
        .rdata_o    (rdata),
        .rid_o      (rid),
        .err_o      (err)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TimeoutCycles) begin
            $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic add_row(input offset_t a, input logic w, input cnt_t c, input len_t l,
                           input logic ew, input data_t d, input logic s,
                           input logic ev, input logic ee);
        row_addr[n_rows]      = a;
        row_we[n_rows]        = w;
        row_cnt[n_rows]       = c;
        row_len[n_rows]       = l;
        row_en_write[n_rows]  = ew;
        row_data[n_rows]      = d;
        row_start[n_rows]     = s;
        row_exp_valid[n_rows] = ev;
        row_exp_err[n_rows]   = ee;
        n_rows++;
    endtask

    // Bits of the response that the card really sends
    function automatic data_t care_mask(input len_t len);
        data_t m;
        for (int i = 0; i < DataWidth; i++) begin
            m[i] = (i <= int'(len));
        end
        return m;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_bit(input string tag, input string name, input logic got,
                             input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %0t: %s %s is %b, expected %b", $time, tag, name, got, exp);
        end
    endtask

    task automatic check_word(input string tag, input string name, input data_t got,
                              input data_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %0t: %s %s is %h, expected %h", $time, tag, name, got, exp);
        end
    endtask

    task automatic run_row(input int r);
        data_t care;
        data_t stim;
        id_t   id;
        string tag;
        tag  = $sformatf("row %0d", r);
        care = care_mask(row_len[r]);
        stim = (row_data[r] & care) | (data_t'($random(seed)) & ~care);
        id   = id_t'($random(seed));
        // Request held for the whole step
        next_cycle();
        req      = 1'b1;
        we       = row_we[r];
        addr     = row_addr[r];
        cnt_cmd  = row_cnt[r];
        len_cmd  = row_len[r];
        en_write = row_en_write[r];
        aid      = id;
        data     = stim;
        spi_clk  = 1'b1;
        next_cycle();
        next_cycle();
        spi_clk   = 1'b0;
        start_bit = row_start[r];
        next_cycle();
        start_bit = 1'b0;
        last_bit  = 1'b1;
        #2;
        check_bit(tag, "done_o", done, row_exp_valid[r]);
        check_bit(tag, "gnt_o", gnt, row_exp_valid[r]);
        next_cycle();
        last_bit = 1'b0;
        #2;
        check_bit(tag, "rvalid_o", rvalid, row_exp_valid[r]);
        check_bit(tag, "err_o", err, row_exp_err[r]);
        check_word(tag, "rid_o", data_t'(rid), data_t'(id));
        if (row_exp_valid[r]) begin
            check_word(tag, "rdata_o", rdata, stim);
        end
        next_cycle();
        req = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_table();
        // addr, we, step, len, en_write, data, start, valid, err
        add_row(Cmd0Offset,   1'b0, 8'd1,   6'd7,  1'b0, 32'h0000_0001, 1'b0, 1'b1, 1'b0);
        add_row(Cmd0Offset,   1'b0, 8'd1,   6'd7,  1'b0, 32'h0000_0005, 1'b0, 1'b1, 1'b1);
        add_row(Cmd59Offset,  1'b0, 8'd1,   6'd7,  1'b0, 32'h0000_0001, 1'b0, 1'b1, 1'b0);
        add_row(Cmd59Offset,  1'b0, 8'd1,   6'd7,  1'b0, 32'h0000_0005, 1'b0, 1'b1, 1'b1);
        add_row(Cmd8Offset,   1'b0, 8'd2,   6'd31, 1'b0, 32'h0100_0003, 1'b0, 1'b1, 1'b1);
        add_row(Cmd8Offset,   1'b0, 8'd3,   6'd7,  1'b0, 32'h0000_00AA, 1'b0, 1'b1, 1'b0);
        add_row(IdleOffset,   1'b0, 8'd1,   6'd7,  1'b0, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
        add_row(BaudOffset,   1'b1, 8'd5,   6'd7,  1'b0, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
        add_row(BaudOffset,   1'b0, 8'd5,   6'd7,  1'b0, 32'h0000_0000, 1'b0, 1'b1, 1'b1);
        add_row(Acmd41Offset, 1'b0, 8'd2,   6'd7,  1'b0, 32'h0000_0000, 1'b0, 1'b1, 1'b0);
        // Step 10 repeats the init loop, card still idle
        add_row(Acmd41Offset, 1'b0, 8'd10,  6'd7,  1'b0, 32'h0000_0001, 1'b0, 1'b0, 1'b0);
        // Plain write range
        add_row(8'h40,        1'b1, 8'd68,  6'd7,  1'b0, 32'h0000_0005, 1'b0, 1'b0, 1'b0);
        add_row(8'h40,        1'b1, 8'd68,  6'd7,  1'b0, 32'h0000_0007, 1'b0, 1'b1, 1'b1);
        add_row(8'h40,        1'b1, 8'd1,   6'd7,  1'b0, 32'h0000_0000, 1'b0, 1'b1, 1'b1);
        add_row(8'h40,        1'b1, 8'd1,   6'd7,  1'b1, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
        // Plain read range
        add_row(8'h40,        1'b0, 8'd2,   6'd7,  1'b0, 32'h0000_0000, 1'b1, 1'b1, 1'b0);
        add_row(8'h40,        1'b0, 8'd127, 6'd7,  1'b0, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
        add_row(8'h7F,        1'b0, 8'd100, 6'd7,  1'b0, 32'h0000_0000, 1'b1, 1'b1, 1'b0);
        add_row(8'h20,        1'b0, 8'd130, 6'd7,  1'b0, 32'h0000_0000, 1'b0, 1'b0, 1'b0);
        add_row(8'h40,        1'b0, 8'd130, 6'd7,  1'b0, 32'h0000_0001, 1'b0, 1'b1, 1'b1);
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        spi_clk   = 1'b0;
        req       = 1'b0;
        we        = 1'b0;
        addr      = '0;
        aid       = '0;
        data      = '0;
        cnt_cmd   = '0;
        len_cmd   = '0;
        en_write  = 1'b0;
        start_bit = 1'b0;
        last_bit  = 1'b0;
        load_table();

        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        #2;
        // Idle bus right after reset
        check_bit("reset", "rvalid_o", rvalid, 1'b0);
        check_bit("reset", "err_o", err, 1'b0);
        check_bit("reset", "gnt_o", gnt, 1'b1);

        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        next_cycle();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
logic/sd_resp_pkg.sv
logic/sd_cmd_expect.sv
logic/sd_resp_judge.sv
logic/sd_obi_resp.sv
logic/sd_resp_checker.sv
tb/sd_resp_checker_properties.sv
tb/tb_sd_resp_checker.sv

// File: Makefile
# Verilator simulation of the SD response checker

TOP := tb_sd_resp_checker
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f all.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
